/* hdl/glitc_sample_pkg.sv */
//////////////////////////////
// Sample, block and beam power definitions for the coincidence trigger.
// Import into any module that handles channel blocks, windows or beam powers.
//////////////////////////////
`default_nettype none

package glitc_sample_pkg;

	// One signed RITC sample.
	localparam int SAMPLE_W = 3;
	// Samples per channel on each system clock.
	localparam int BLOCK_LEN = 16;
	localparam int BLOCK_W = BLOCK_LEN * SAMPLE_W;
	// Previous block plus current block.
	localparam int WINDOW_LEN = 2 * BLOCK_LEN;
	// Sixteen squares of at most 144 each fit in 12 bits.
	localparam int POWER_W = 12;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Sample 0 is the oldest and sits in the low bits.
	typedef sample_t [BLOCK_LEN-1:0] block_t;

	// Positions 0 to 15 hold the previous block, 16 to 31 the current one.
	typedef sample_t [WINDOW_LEN-1:0] window_t;

	typedef logic [POWER_W-1:0] power_t;

endpackage

`default_nettype wire

/* hdl/glitc_reg_pkg.sv */
//////////////////////////////
// User bus widths, register map, version word and reset values
// for the trigger control register block.
//////////////////////////////
`default_nettype none

package glitc_reg_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	// Register map.
	localparam logic [ADDR_W-1:0] REG_VERSION = 4'd0;
	localparam logic [ADDR_W-1:0] REG_CONTROL = 4'd1;
	localparam logic [ADDR_W-1:0] REG_THRESHOLD = 4'd2;
	localparam logic [ADDR_W-1:0] REG_BEAM_MASK = 4'd3;
	localparam logic [ADDR_W-1:0] REG_TRIG_COUNT = 4'd4;
	localparam logic [ADDR_W-1:0] REG_LAST_MAX = 4'd5;

	// Beam index position in the last-result word.
	localparam int LAST_BEAM_LSB = 16;

	// Version word fields.
	localparam logic [3:0] VER_BOARDREV = 4'd1;
	localparam logic [3:0] VER_MONTH = 4'd3;
	localparam logic [7:0] VER_DAY = 8'd12;
	localparam logic [3:0] VER_MAJOR = 4'd1;
	localparam logic [3:0] VER_MINOR = 4'd0;
	localparam logic [7:0] VER_REV = 8'd5;
	localparam logic [DATA_W-1:0] VERSION =
		{VER_BOARDREV, VER_MONTH, VER_DAY, VER_MAJOR, VER_MINOR, VER_REV};

	localparam logic [DATA_W-1:0] THRESHOLD_RESET = 32'd4095;
	localparam logic [DATA_W-1:0] MASK_RESET = '1;

endpackage

`default_nettype wire

/* hdl/sample_window_builder.sv */
//////////////////////////////
// Window builder for one group of three channels.
// Joins the stored previous block of each channel with the new block
// and issues a registered 32-sample window one cycle after in_valid_i.
//////////////////////////////
`default_nettype none

module sample_window_builder
	import glitc_sample_pkg::*;
(
	input wire logic sysclk_i,
	input wire logic reset_i,
	input wire logic enable_i,

	input wire logic in_valid_i,
	input wire block_t ch_a_i,
	input wire block_t ch_b_i,
	input wire block_t ch_c_i,

	output logic win_valid_o,
	output window_t win_a_o,
	output window_t win_b_o,
	output window_t win_c_o
);

	// A block offered while disabled is dropped entirely.
	logic accept;

	logic [BLOCK_W-1:0] prev_a_q;
	logic [BLOCK_W-1:0] prev_b_q;
	logic [BLOCK_W-1:0] prev_c_q;

	logic win_valid_q;
	window_t win_a_q;
	window_t win_b_q;
	window_t win_c_q;

	assign accept = in_valid_i && enable_i;

	//////////////////////////////
	// Previous block store.
	//////////////////////////////
	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			prev_a_q <= '0;
			prev_b_q <= '0;
			prev_c_q <= '0;
		end else if (accept) begin
			prev_a_q <= ch_a_i;
			prev_b_q <= ch_b_i;
			prev_c_q <= ch_c_i;
		end
	end

	//////////////////////////////
	// Window output.
	//////////////////////////////
	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			win_valid_q <= 1'b0;
		end else begin
			win_valid_q <= accept;
		end
	end

	// The new block lands in the upper half, previous block in the lower.
	always_ff @(posedge sysclk_i) begin
		if (accept) begin
			win_a_q <= {ch_a_i, prev_a_q};
			win_b_q <= {ch_b_i, prev_b_q};
			win_c_q <= {ch_c_i, prev_c_q};
		end
	end

	assign win_valid_o = win_valid_q;
	assign win_a_o = win_a_q;
	assign win_b_o = win_b_q;
	assign win_c_o = win_c_q;

endmodule

`default_nettype wire

/* hdl/beam_power_sum.sv */
//////////////////////////////
// Phased sum of squares for one beam.
// BEAM delays channel B by BEAM samples and channel C by twice that.
// Power comes out two cycles after win_valid_i.
//////////////////////////////
`default_nettype none

module beam_power_sum
	import glitc_sample_pkg::*;
#(
	parameter int BEAM = 0
) (
	input wire logic sysclk_i,
	input wire logic reset_i,

	input wire logic win_valid_i,
	input wire window_t win_a_i,
	input wire window_t win_b_i,
	input wire window_t win_c_i,

	output power_t power_o,
	output logic valid_o
);

	// Three 3-bit samples sum to at most 12 in magnitude.
	localparam int SUM_W = SAMPLE_W + 2;
	localparam int PROD_W = 2 * SUM_W;
	// A square is at most 144.
	localparam int SQ_W = PROD_W - 2;

	logic signed [SUM_W-1:0] phased [BLOCK_LEN];
	logic signed [PROD_W-1:0] product [BLOCK_LEN];
	logic [SQ_W-1:0] square_q [BLOCK_LEN];
	logic square_valid_q;

	power_t total;
	power_t power_q;
	logic valid_q;

	//////////////////////////////
	// Stage one: phase align and square.
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < BLOCK_LEN; i++) begin
			phased[i] = SUM_W'($signed(win_a_i[BLOCK_LEN + i]))
				+ SUM_W'($signed(win_b_i[BLOCK_LEN + i - BEAM]))
				+ SUM_W'($signed(win_c_i[BLOCK_LEN + i - 2 * BEAM]));
			product[i] = PROD_W'(phased[i]) * PROD_W'(phased[i]);
		end
	end

	always_ff @(posedge sysclk_i) begin
		for (int i = 0; i < BLOCK_LEN; i++) begin
			square_q[i] <= product[i][SQ_W-1:0];
		end
	end

	//////////////////////////////
	// Stage two: add the squares.
	//////////////////////////////
	always_comb begin
		total = '0;
		for (int i = 0; i < BLOCK_LEN; i++) begin
			total = total + POWER_W'(square_q[i]);
		end
	end

	always_ff @(posedge sysclk_i) begin
		power_q <= total;
	end

	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			square_valid_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			square_valid_q <= win_valid_i;
			valid_q <= square_valid_q;
		end
	end

	assign power_o = power_q;
	assign valid_o = valid_q;

endmodule

`default_nettype wire

/* hdl/beam_max_select.sv */
//////////////////////////////
// Picks the strongest unmasked beam and compares it with the threshold.
// Result and trigger are registered one cycle after valid_i.
// Ties go to the lowest beam index.
//////////////////////////////
`default_nettype none

module beam_max_select
	import glitc_sample_pkg::*;
#(
	parameter int NUM_BEAMS = 8,
	localparam int BEAM_W = (NUM_BEAMS > 1) ? $clog2(NUM_BEAMS) : 1
) (
	input wire logic sysclk_i,
	input wire logic reset_i,

	input wire logic valid_i,
	input wire power_t powers_i [NUM_BEAMS],
	input wire logic [NUM_BEAMS-1:0] beam_mask_i,
	input wire power_t threshold_i,

	output logic max_valid_o,
	output power_t max_power_o,
	output logic [BEAM_W-1:0] max_beam_o,
	output logic trigger_o
);

	power_t best_power;
	logic [BEAM_W-1:0] best_beam;

	logic max_valid_q;
	logic trigger_q;
	power_t max_power_q;
	logic [BEAM_W-1:0] max_beam_q;

	// Masked beams count as zero, strict compare keeps the lowest index.
	always_comb begin
		best_power = '0;
		best_beam = '0;
		for (int k = 0; k < NUM_BEAMS; k++) begin
			if (beam_mask_i[k] && (powers_i[k] > best_power)) begin
				best_power = powers_i[k];
				best_beam = BEAM_W'(k);
			end
		end
	end

	//////////////////////////////
	// Result registers.
	//////////////////////////////
	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			max_valid_q <= 1'b0;
			trigger_q <= 1'b0;
		end else begin
			max_valid_q <= valid_i;
			trigger_q <= valid_i && (best_power >= threshold_i);
		end
	end

	always_ff @(posedge sysclk_i) begin
		if (valid_i) begin
			max_power_q <= best_power;
			max_beam_q <= best_beam;
		end
	end

	assign max_valid_o = max_valid_q;
	assign trigger_o = trigger_q;
	assign max_power_o = max_power_q;
	assign max_beam_o = max_beam_q;

endmodule

`default_nettype wire

/* hdl/glitc_control_regs.sv */
//////////////////////////////
// Control and status registers on the local user bus.
// Holds enable, threshold and beam mask, counts triggers and keeps
// the last maximum. Read data appears one cycle after the read strobe.
//////////////////////////////
`default_nettype none

module glitc_control_regs
	import glitc_sample_pkg::*, glitc_reg_pkg::*;
#(
	parameter int NUM_BEAMS = 8,
	localparam int BEAM_W = (NUM_BEAMS > 1) ? $clog2(NUM_BEAMS) : 1
) (
	input wire logic sysclk_i,
	input wire logic reset_i,

	input wire logic user_sel_i,
	input wire logic user_wr_i,
	input wire logic user_rd_i,
	input wire logic [ADDR_W-1:0] user_addr_i,
	input wire logic [DATA_W-1:0] user_dat_i,

	input wire logic max_valid_i,
	input wire power_t max_power_i,
	input wire logic [BEAM_W-1:0] max_beam_i,
	input wire logic trigger_i,

	output logic [DATA_W-1:0] user_dat_o,
	output logic enable_o,
	output power_t threshold_o,
	output logic [NUM_BEAMS-1:0] beam_mask_o
);

	logic enable_q;
	power_t threshold_q;
	logic [NUM_BEAMS-1:0] mask_q;

	logic [DATA_W-1:0] trig_count_q;
	power_t last_power_q;
	logic [BEAM_W-1:0] last_beam_q;

	logic [DATA_W-1:0] rd_data;
	logic [DATA_W-1:0] user_dat_q;

	//////////////////////////////
	// Writable registers.
	//////////////////////////////
	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			enable_q <= 1'b0;
			threshold_q <= THRESHOLD_RESET[POWER_W-1:0];
			mask_q <= MASK_RESET[NUM_BEAMS-1:0];
		end else if (user_sel_i && user_wr_i) begin
			case (user_addr_i)
				REG_CONTROL: enable_q <= user_dat_i[0];
				REG_THRESHOLD: threshold_q <= user_dat_i[POWER_W-1:0];
				REG_BEAM_MASK: mask_q <= user_dat_i[NUM_BEAMS-1:0];
				// Read-only and unmapped addresses ignore writes.
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// Trigger statistics.
	//////////////////////////////
	// Saturates at all ones.
	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			trig_count_q <= '0;
		end else if (trigger_i && (trig_count_q != '1)) begin
			trig_count_q <= trig_count_q + 1'b1;
		end
	end

	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			last_power_q <= '0;
			last_beam_q <= '0;
		end else if (max_valid_i) begin
			last_power_q <= max_power_i;
			last_beam_q <= max_beam_i;
		end
	end

	//////////////////////////////
	// Read path.
	//////////////////////////////
	always_comb begin
		rd_data = '0;
		case (user_addr_i)
			REG_VERSION: rd_data = VERSION;
			REG_CONTROL: rd_data[0] = enable_q;
			REG_THRESHOLD: rd_data[POWER_W-1:0] = threshold_q;
			REG_BEAM_MASK: rd_data[NUM_BEAMS-1:0] = mask_q;
			REG_TRIG_COUNT: rd_data = trig_count_q;
			REG_LAST_MAX: begin
				rd_data[POWER_W-1:0] = last_power_q;
				rd_data[LAST_BEAM_LSB +: BEAM_W] = last_beam_q;
			end
			default: rd_data = '0;
		endcase
	end

	// Data holds until the next read strobe.
	always_ff @(posedge sysclk_i) begin
		if (reset_i) begin
			user_dat_q <= '0;
		end else if (user_sel_i && user_rd_i) begin
			user_dat_q <= rd_data;
		end
	end

	assign user_dat_o = user_dat_q;
	assign enable_o = enable_q;
	assign threshold_o = threshold_q;
	assign beam_mask_o = mask_q;

endmodule

`default_nettype wire

/* hdl/glitc_beam_trigger.sv */
//////////////////////////////
// Coincidence trigger core for one three-channel group.
// Window builder feeds NUM_BEAMS beam summers, the max selector
// raises the trigger four cycles after each accepted block.
// Control sits on the user bus.
//////////////////////////////
`default_nettype none

module glitc_beam_trigger
	import glitc_sample_pkg::*, glitc_reg_pkg::*;
#(
	parameter int NUM_BEAMS = 8,
	localparam int BEAM_W = (NUM_BEAMS > 1) ? $clog2(NUM_BEAMS) : 1
) (
	input wire logic sysclk_i,
	input wire logic reset_i,

	input wire logic in_valid_i,
	input wire block_t ch_a_i,
	input wire block_t ch_b_i,
	input wire block_t ch_c_i,

	input wire logic user_sel_i,
	input wire logic user_wr_i,
	input wire logic user_rd_i,
	input wire logic [ADDR_W-1:0] user_addr_i,
	input wire logic [DATA_W-1:0] user_dat_i,
	output logic [DATA_W-1:0] user_dat_o,

	output logic max_valid_o,
	output power_t max_power_o,
	output logic [BEAM_W-1:0] max_beam_o,
	output logic trigger_o
);

	logic enable;
	power_t threshold;
	logic [NUM_BEAMS-1:0] beam_mask;

	logic win_valid;
	window_t win_a;
	window_t win_b;
	window_t win_c;

	power_t beam_power [NUM_BEAMS];
	logic [NUM_BEAMS-1:0] beam_valid;

	//////////////////////////////
	// Feeder.
	//////////////////////////////
	sample_window_builder sample_window_builder_i (
		.sysclk_i(sysclk_i),
		.reset_i(reset_i),
		.enable_i(enable),
		.in_valid_i(in_valid_i),
		.ch_a_i(ch_a_i),
		.ch_b_i(ch_b_i),
		.ch_c_i(ch_c_i),
		.win_valid_o(win_valid),
		.win_a_o(win_a),
		.win_b_o(win_b),
		.win_c_o(win_c)
	);

	//////////////////////////////
	// Beam summers.
	//////////////////////////////
	for (genvar k = 0; k < NUM_BEAMS; k++) begin : g_beam
		beam_power_sum #(
			.BEAM(k)
		) beam_power_sum_i (
			.sysclk_i(sysclk_i),
			.reset_i(reset_i),
			.win_valid_i(win_valid),
			.win_a_i(win_a),
			.win_b_i(win_b),
			.win_c_i(win_c),
			.power_o(beam_power[k]),
			.valid_o(beam_valid[k])
		);
	end

	//////////////////////////////
	// Drain.
	//////////////////////////////
	// All summers share one timing, so beam 0 qualifies the whole bank.
	beam_max_select #(
		.NUM_BEAMS(NUM_BEAMS)
	) beam_max_select_i (
		.sysclk_i(sysclk_i),
		.reset_i(reset_i),
		.valid_i(beam_valid[0]),
		.powers_i(beam_power),
		.beam_mask_i(beam_mask),
		.threshold_i(threshold),
		.max_valid_o(max_valid_o),
		.max_power_o(max_power_o),
		.max_beam_o(max_beam_o),
		.trigger_o(trigger_o)
	);

	glitc_control_regs #(
		.NUM_BEAMS(NUM_BEAMS)
	) glitc_control_regs_i (
		.sysclk_i(sysclk_i),
		.reset_i(reset_i),
		.user_sel_i(user_sel_i),
		.user_wr_i(user_wr_i),
		.user_rd_i(user_rd_i),
		.user_addr_i(user_addr_i),
		.user_dat_i(user_dat_i),
		.max_valid_i(max_valid_o),
		.max_power_i(max_power_o),
		.max_beam_i(max_beam_o),
		.trigger_i(trigger_o),
		.user_dat_o(user_dat_o),
		.enable_o(enable),
		.threshold_o(threshold),
		.beam_mask_o(beam_mask)
	);

endmodule

`default_nettype wire

/* bench/glitc_beam_trigger_tb.sv */
//////////////////////////////
// Testbench for the coincidence trigger core.
// Drives random channel blocks, models every beam power and checks
// the selector result and the user bus registers with assertions.
//////////////////////////////
`default_nettype none

module glitc_beam_trigger_tb
	import glitc_sample_pkg::*, glitc_reg_pkg::*;
();

	localparam int NUM_BEAMS = 8;
	localparam int BEAM_W = 3;

	logic sysclk_i;
	logic reset_i;
	logic in_valid_i;
	block_t ch_a_i;
	block_t ch_b_i;
	block_t ch_c_i;
	logic user_sel_i;
	logic user_wr_i;
	logic user_rd_i;
	logic [ADDR_W-1:0] user_addr_i;
	logic [DATA_W-1:0] user_dat_i;
	logic [DATA_W-1:0] user_dat_o;
	logic max_valid_o;
	power_t max_power_o;
	logic [BEAM_W-1:0] max_beam_o;
	logic trigger_o;

	// Reference model state.
	int seed;
	int prev_a [BLOCK_LEN];
	int prev_b [BLOCK_LEN];
	int prev_c [BLOCK_LEN];
	int cur_a [BLOCK_LEN];
	int cur_b [BLOCK_LEN];
	int cur_c [BLOCK_LEN];
	bit model_enable;
	int model_threshold;
	logic [NUM_BEAMS-1:0] model_mask;
	int exp_power_q [$];
	int exp_beam_q [$];
	bit exp_trig_q [$];
	int exp_trig_count;
	int last_power;
	int last_beam;

	// Expected values lined up with the DUT outputs.
	logic [3:0] exp_sr = '0;
	int exp_power_r = 0;
	int exp_beam_r = 0;
	bit exp_trig_r = 1'b0;
	bit rd_chk = 1'b0;
	logic [DATA_W-1:0] rd_exp = '0;
	int cycle = 0;
	int value_errors = 0;
	int other_errors = 0;
	int p;
	int k;
	int thr;

	glitc_beam_trigger #(
		.NUM_BEAMS(NUM_BEAMS)
	) glitc_beam_trigger_i (
		.sysclk_i(sysclk_i),
		.reset_i(reset_i),
		.in_valid_i(in_valid_i),
		.ch_a_i(ch_a_i),
		.ch_b_i(ch_b_i),
		.ch_c_i(ch_c_i),
		.user_sel_i(user_sel_i),
		.user_wr_i(user_wr_i),
		.user_rd_i(user_rd_i),
		.user_addr_i(user_addr_i),
		.user_dat_i(user_dat_i),
		.user_dat_o(user_dat_o),
		.max_valid_o(max_valid_o),
		.max_power_o(max_power_o),
		.max_beam_o(max_beam_o),
		.trigger_o(trigger_o)
	);

	initial begin
		sysclk_i = 1'b0;
		forever #2 sysclk_i = ~sysclk_i;
	end

	// Four stages from an accepted block to max_valid_o.
	always @(posedge sysclk_i) begin
		cycle <= cycle + 1;
		if (reset_i) begin
			exp_sr <= '0;
		end else begin
			exp_sr <= {exp_sr[2:0], in_valid_i && model_enable};
		end
	end

	always @(negedge sysclk_i) begin
		if (!reset_i && max_valid_o) begin
			if (exp_power_q.size() == 0) begin
				other_errors++;
				$display("max_valid_o rose at %0t with no result pending", $time);
			end else begin
				exp_power_r = exp_power_q.pop_front();
				exp_beam_r = exp_beam_q.pop_front();
				exp_trig_r = exp_trig_q.pop_front();
			end
		end
	end

	//////////////////////////////
	// Checks.
	//////////////////////////////
	a_valid: assert property (@(posedge sysclk_i) (cycle > 1) |-> (max_valid_o == exp_sr[3]))
		else begin
			value_errors++;
			$display("error t=%0t max_valid_o expected %0b got %0b",
				$time, $sampled(exp_sr[3]), $sampled(max_valid_o));
		end

	a_trigger: assert property (@(posedge sysclk_i)
		(cycle > 1) |-> (trigger_o == (exp_sr[3] && exp_trig_r)))
		else begin
			value_errors++;
			$display("error t=%0t trigger_o expected %0b got %0b",
				$time, $sampled(exp_sr[3] && exp_trig_r), $sampled(trigger_o));
		end

	a_power: assert property (@(posedge sysclk_i) disable iff (reset_i)
		max_valid_o |-> (int'(max_power_o) == exp_power_r))
		else begin
			value_errors++;
			$display("error t=%0t max_power_o expected %0d got %0d",
				$time, $sampled(exp_power_r), $sampled(max_power_o));
		end

	a_beam: assert property (@(posedge sysclk_i) disable iff (reset_i)
		max_valid_o |-> (int'(max_beam_o) == exp_beam_r))
		else begin
			value_errors++;
			$display("error t=%0t max_beam_o expected %0d got %0d",
				$time, $sampled(exp_beam_r), $sampled(max_beam_o));
		end

	a_read: assert property (@(posedge sysclk_i) rd_chk |-> (user_dat_o == rd_exp))
		else begin
			value_errors++;
			$display("error t=%0t user_dat_o expected %h got %h",
				$time, $sampled(rd_exp), $sampled(user_dat_o));
		end

	//////////////////////////////
	// Model and bus tasks.
	//////////////////////////////
	// Strongest unmasked beam of the current block, ties to the lowest index.
	function automatic void compute_max(output int best_p, output int best_k);
		int win_a [WINDOW_LEN];
		int win_b [WINDOW_LEN];
		int win_c [WINDOW_LEN];
		int s;
		int pw;
		for (int i = 0; i < BLOCK_LEN; i++) begin
			win_a[i] = prev_a[i];
			win_b[i] = prev_b[i];
			win_c[i] = prev_c[i];
			win_a[BLOCK_LEN + i] = cur_a[i];
			win_b[BLOCK_LEN + i] = cur_b[i];
			win_c[BLOCK_LEN + i] = cur_c[i];
		end
		best_p = 0;
		best_k = 0;
		for (int b = 0; b < NUM_BEAMS; b++) begin
			pw = 0;
			for (int i = 0; i < BLOCK_LEN; i++) begin
				s = win_a[16 + i] + win_b[16 + i - b] + win_c[16 + i - 2 * b];
				pw += s * s;
			end
			if (model_mask[b] && (pw > best_p)) begin
				best_p = pw;
				best_k = b;
			end
		end
	endfunction

	// Mode 0 is fully random, 1 drives channel A only, 2 is all zero.
	task automatic make_block(input int mode);
		for (int i = 0; i < BLOCK_LEN; i++) begin
			cur_a[i] = (mode == 2) ? 0 : (($random(seed) & 7) - 4);
			cur_b[i] = (mode == 0) ? (($random(seed) & 7) - 4) : 0;
			cur_c[i] = (mode == 0) ? (($random(seed) & 7) - 4) : 0;
		end
	endtask

	task automatic drive_block(input int gap);
		int bp;
		int bk;
		bit trig;
		for (int i = 0; i < BLOCK_LEN; i++) begin
			ch_a_i[i] = SAMPLE_W'(cur_a[i]);
			ch_b_i[i] = SAMPLE_W'(cur_b[i]);
			ch_c_i[i] = SAMPLE_W'(cur_c[i]);
		end
		in_valid_i = 1'b1;
		if (model_enable) begin
			compute_max(bp, bk);
			trig = (bp >= model_threshold);
			exp_power_q.push_back(bp);
			exp_beam_q.push_back(bk);
			exp_trig_q.push_back(trig);
			if (trig) begin
				exp_trig_count++;
			end
			last_power = bp;
			last_beam = bk;
			prev_a = cur_a;
			prev_b = cur_b;
			prev_c = cur_c;
		end
		@(negedge sysclk_i);
		in_valid_i = 1'b0;
		repeat (gap) @(negedge sysclk_i);
	endtask

	task automatic drain(input string what);
		int waited;
		waited = 0;
		while ((exp_power_q.size() != 0) && (waited < 20)) begin
			@(negedge sysclk_i);
			waited++;
		end
		if (exp_power_q.size() != 0) begin
			other_errors++;
			$display("timeout: results for %s never arrived", what);
		end
		// Let the status registers take the last result.
		repeat (2) @(negedge sysclk_i);
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		user_sel_i = 1'b1;
		user_wr_i = 1'b1;
		user_addr_i = addr;
		user_dat_i = data;
		@(negedge sysclk_i);
		user_sel_i = 1'b0;
		user_wr_i = 1'b0;
		case (addr)
			REG_CONTROL: model_enable = data[0];
			REG_THRESHOLD: model_threshold = int'(data[POWER_W-1:0]);
			REG_BEAM_MASK: model_mask = data[NUM_BEAMS-1:0];
			default: ;
		endcase
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
		user_sel_i = 1'b1;
		user_rd_i = 1'b1;
		user_addr_i = addr;
		@(negedge sysclk_i);
		user_sel_i = 1'b0;
		user_rd_i = 1'b0;
		rd_exp = expected;
		rd_chk = 1'b1;
		@(negedge sysclk_i);
		rd_chk = 1'b0;
	endtask

	//////////////////////////////
	// Stimulus.
	//////////////////////////////
	initial begin
		seed = 32'h43fd;
		reset_i = 1'b1;
		in_valid_i = 1'b0;
		ch_a_i = '0;
		ch_b_i = '0;
		ch_c_i = '0;
		user_sel_i = 1'b0;
		user_wr_i = 1'b0;
		user_rd_i = 1'b0;
		user_addr_i = '0;
		user_dat_i = '0;
		model_enable = 1'b0;
		model_threshold = 4095;
		model_mask = '1;
		exp_trig_count = 0;
		last_power = 0;
		last_beam = 0;
		for (int i = 0; i < BLOCK_LEN; i++) begin
			prev_a[i] = 0;
			prev_b[i] = 0;
			prev_c[i] = 0;
		end
		repeat (10) @(posedge sysclk_i);
		@(negedge sysclk_i);
		reset_i = 1'b0;
		@(negedge sysclk_i);

		// Register reset values and write-back.
		read_check(REG_VERSION, VERSION);
		read_check(REG_THRESHOLD, 32'h0000_0fff);
		read_check(REG_BEAM_MASK, 32'h0000_00ff);
		read_check(REG_CONTROL, 32'h0);
		write_reg(REG_THRESHOLD, 32'd1500);
		read_check(REG_THRESHOLD, 32'd1500);
		write_reg(REG_BEAM_MASK, 32'h5a);
		read_check(REG_BEAM_MASK, 32'h5a);
		write_reg(REG_VERSION, 32'h0);
		read_check(REG_VERSION, VERSION);
		write_reg(REG_BEAM_MASK, 32'hff);
		write_reg(REG_CONTROL, 32'h1);
		read_check(REG_CONTROL, 32'h1);

		// Back-to-back, gapped, then equal-power blocks.
		for (int n = 0; n < 12; n++) begin
			make_block(0);
			drive_block(0);
		end
		for (int n = 0; n < 8; n++) begin
			make_block(0);
			drive_block(n % 3 + 1);
		end
		make_block(1);
		drive_block(0);
		make_block(1);
		drive_block(1);
		make_block(2);
		drive_block(0);
		drain("unmasked blocks");

		// Partial mask, then every beam masked.
		write_reg(REG_BEAM_MASK, 32'ha6);
		for (int n = 0; n < 6; n++) begin
			make_block(0);
			drive_block(0);
		end
		make_block(1);
		drive_block(0);
		make_block(1);
		drive_block(0);
		drain("partly masked blocks");
		write_reg(REG_BEAM_MASK, 32'h0);
		for (int n = 0; n < 3; n++) begin
			make_block(0);
			drive_block(0);
		end
		drain("fully masked blocks");
		write_reg(REG_BEAM_MASK, 32'hff);

		// Threshold just below, at and just above the maximum.
		for (int n = 0; n < 3; n++) begin
			make_block(0);
			compute_max(p, k);
			thr = (p + n - 1 < 0) ? 0 : p + n - 1;
			write_reg(REG_THRESHOLD, DATA_W'(thr));
			drive_block(0);
			drain("threshold blocks");
		end
		// Near the typical strongest beam, so some blocks trigger and some do not.
		write_reg(REG_THRESHOLD, 32'd400);
		for (int n = 0; n < 8; n++) begin
			make_block(0);
			drive_block(n % 2);
		end
		drain("mixed trigger blocks");
		read_check(REG_TRIG_COUNT, DATA_W'(exp_trig_count));
		read_check(REG_LAST_MAX, DATA_W'((last_beam << LAST_BEAM_LSB) | last_power));

		// Disabled blocks leave the previous block alone.
		write_reg(REG_CONTROL, 32'h0);
		for (int n = 0; n < 5; n++) begin
			make_block(0);
			drive_block(1);
		end
		write_reg(REG_CONTROL, 32'h1);
		make_block(0);
		drive_block(0);
		drain("block after re-enable");

		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0)) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hdl/glitc_sample_pkg.sv
hdl/glitc_reg_pkg.sv
hdl/sample_window_builder.sv
hdl/beam_power_sum.sv
hdl/beam_max_select.sv
hdl/glitc_control_regs.sv
hdl/glitc_beam_trigger.sv
bench/glitc_beam_trigger_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the trigger core testbench with Verilator and runs it.
# Exits non-zero when the testbench reports errors.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module glitc_beam_trigger_tb \
	-f flist.f \
	-o glitc_beam_trigger_tb

./obj_dir/glitc_beam_trigger_tb | tee sim.log

if grep -q "Done: errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0
